// ==== verilog/exec_pkg.sv ====
// Shared definitions for the execute subsystem
//   op_e        operation codes
//   exec_cmd_t  command word set from the issue side
//   exec_cpl_t  completion record returned in order
//   alu_out_t   ALU value and compare flag
//   MEM_DEPTH / MEM_AW  data memory size and address width
`default_nettype none

package exec_pkg;

    // Data memory geometry
    localparam int MEM_DEPTH = 256;             // Words
    localparam int MEM_AW    = $clog2(MEM_DEPTH);

    // Operation codes, 7 bits like the RISC-V opcode field
    typedef enum logic [6:0] {
        OP_ADD = 7'd0,
        OP_SUB = 7'd1,
        OP_AND = 7'd2,
        OP_OR  = 7'd3,
        OP_BEQ = 7'd4,
        OP_BNE = 7'd5,
        OP_LW  = 7'd6,  // operand1 is the word address
        OP_SW  = 7'd7   // operand2 is the store data
    } op_e;

    // One command from the issue side
    typedef struct packed {
        op_e         op;
        logic [31:0] operand1;
        logic [31:0] operand2;
    } exec_cmd_t;

    // One completion record
    typedef struct packed {
        op_e         op;            // Echo of the command code
        logic [31:0] result;        // ALU value, load data or zero
        logic        branch_taken;
        logic [31:0] target;        // operand1 when taken, else zero
        logic        illegal;       // Unknown op code
    } exec_cpl_t;

    // ALU result as seen by the stage
    typedef struct packed {
        logic [31:0] value;
        logic        taken;         // Branch condition met
    } alu_out_t;

endpackage

`default_nettype wire

// ==== verilog/exec_alu.sv ====
// Combinational ALU for the execute stage
//   ADD, SUB, AND, OR value
//   BEQ / BNE condition from one equality compare
`timescale 1ns/100ps
`default_nettype none

module exec_alu import exec_pkg::*; (
    input  op_e         op,
    input  logic [31:0] operand1,
    input  logic [31:0] operand2,
    output alu_out_t    alu_out
);

    logic [31:0] sum;
    logic [31:0] diff;
    logic        equal;

    assign sum   = operand1 + operand2;   // Wraps at 32 bits
    assign diff  = operand1 - operand2;
    assign equal = (operand1 == operand2);

    // Value select
    always_comb begin
        case (op)
            OP_ADD: begin
                alu_out.value = sum;
            end
            OP_SUB: begin
                alu_out.value = diff;
            end
            OP_AND: begin
                alu_out.value = operand1 & operand2;
            end
            OP_OR: begin
                alu_out.value = operand1 | operand2;
            end
            default: begin
                alu_out.value = 32'd0;  // Branches, memory ops, unknown codes
            end
        endcase
    end

    // Branch condition, BNE is the inverted compare
    always_comb begin
        case (op)
            OP_BEQ: begin
                alu_out.taken = equal;
            end
            OP_BNE: begin
                alu_out.taken = ~equal;
            end
            default: begin
                alu_out.taken = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/data_mem.sv ====
// Private data memory of the execute subsystem
//   MEM_DEPTH words of 32 bits, word addressed
//   Write on the enabled edge, registered read
`timescale 1ns/100ps
`default_nettype none

module data_mem import exec_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              mem_en,
    input  logic              mem_we,
    input  logic [MEM_AW-1:0] mem_addr,
    input  logic [31:0]       mem_wdata,
    output logic [31:0]       mem_rdata
);

    logic [31:0] mem [MEM_DEPTH];

    logic wr_en;
    logic rd_en;

    assign wr_en = mem_en & mem_we;
    assign rd_en = mem_en & ~mem_we;

    // Storage array, contents undefined until written
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[mem_addr] <= mem_wdata;
        end
    end

    // Read port, data valid the cycle after the enable
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_rdata <= 32'd0;
        end else if (rd_en) begin
            mem_rdata <= mem[mem_addr];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/exec_stage.sv ====
// Execute stage
//   Command accept with valid/ready, one command in flight
//   Decode of ALU, branch, load, store and illegal codes
//   One-cycle load wait on the memory read
//   Completion register held under back-pressure
`timescale 1ns/100ps
`default_nettype none

module exec_stage import exec_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,

    // Command port
    input  logic              cmd_valid,
    output logic              cmd_ready,
    input  exec_cmd_t         cmd,

    // Completion port
    output logic              cpl_valid,
    input  logic              cpl_ready,
    output exec_cpl_t         cpl,

    // ALU
    output op_e               alu_op,
    output logic [31:0]       alu_a,
    output logic [31:0]       alu_b,
    input  alu_out_t          alu_out,

    // Data memory
    output logic              mem_en,
    output logic              mem_we,
    output logic [MEM_AW-1:0] mem_addr,
    output logic [31:0]       mem_wdata,
    input  logic [31:0]       mem_rdata
);

    logic      load_wait;   // LW issued, data arrives next edge
    logic      cmd_accept;
    logic      is_lw;
    logic      is_sw;
    exec_cpl_t imm_cpl;     // Record for single-cycle ops

    // Room when the completion slot frees this cycle and no load pending
    assign cmd_ready  = ~load_wait & (~cpl_valid | cpl_ready);
    assign cmd_accept = cmd_valid & cmd_ready;

    assign is_lw = (cmd.op == OP_LW);
    assign is_sw = (cmd.op == OP_SW);

    // Operands go straight to the ALU
    assign alu_op = cmd.op;
    assign alu_a  = cmd.operand1;
    assign alu_b  = cmd.operand2;

    // Memory access happens on the acceptance edge
    assign mem_en    = cmd_accept & (is_lw | is_sw);
    assign mem_we    = is_sw;
    assign mem_addr  = cmd.operand1[MEM_AW-1:0];   // Low bits select the word
    assign mem_wdata = cmd.operand2;

    // Decode into a completion record
    always_comb begin
        imm_cpl    = '0;
        imm_cpl.op = cmd.op;
        case (cmd.op)
            OP_ADD, OP_SUB, OP_AND, OP_OR: begin
                imm_cpl.result = alu_out.value;
            end
            OP_BEQ, OP_BNE: begin
                imm_cpl.branch_taken = alu_out.taken;
                imm_cpl.target       = alu_out.taken ? cmd.operand1 : 32'd0;
            end
            OP_LW, OP_SW: begin
                imm_cpl.result = 32'd0;   // LW result is filled from the memory
            end
            default: begin
                imm_cpl.illegal = 1'b1;
            end
        endcase
    end

    // Handshake state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cpl_valid <= 1'b0;
            load_wait <= 1'b0;
        end else begin
            if (load_wait) begin
                // Read data is on mem_rdata now
                load_wait <= 1'b0;
                cpl_valid <= 1'b1;
            end else if (cmd_accept) begin
                load_wait <= is_lw;
                cpl_valid <= ~is_lw;   // Slot empties while the load waits
            end else if (cpl_valid && cpl_ready) begin
                cpl_valid <= 1'b0;
            end
        end
    end

    // Completion payload, only loaded when the slot is free
    always_ff @(posedge clk) begin
        if (load_wait) begin
            cpl <= '{
                op:           OP_LW,
                result:       mem_rdata,
                branch_taken: 1'b0,
                target:       32'd0,
                illegal:      1'b0
            };
        end else if (cmd_accept && !is_lw) begin
            cpl <= imm_cpl;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/exec_top.sv ====
// Execute subsystem top level
//   exec_stage with its ALU and private data memory
//   No registers here, latency is the stage's
`timescale 1ns/100ps
`default_nettype none

module exec_top import exec_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cmd_valid,
    output logic      cmd_ready,
    input  exec_cmd_t cmd,
    output logic      cpl_valid,
    input  logic      cpl_ready,
    output exec_cpl_t cpl
);

    // Stage to ALU
    op_e         alu_op;
    logic [31:0] alu_a;
    logic [31:0] alu_b;
    alu_out_t    alu_out;

    // Stage to memory
    logic              mem_en;
    logic              mem_we;
    logic [MEM_AW-1:0] mem_addr;
    logic [31:0]       mem_wdata;
    logic [31:0]       mem_rdata;

    exec_stage stage0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .cpl_valid (cpl_valid),
        .cpl_ready (cpl_ready),
        .cpl       (cpl),
        .alu_op    (alu_op),
        .alu_a     (alu_a),
        .alu_b     (alu_b),
        .alu_out   (alu_out),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    exec_alu alu0 (
        .op       (alu_op),
        .operand1 (alu_a),
        .operand2 (alu_b),
        .alu_out  (alu_out)
    );

    data_mem mem0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
// Testbench clock source
//   Free-running clk, 4 ns period
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;  // Half period
        end
    end

endmodule

`default_nettype wire

// ==== tb/exec_checker.sv ====
// Completion checker for the execute subsystem
//   Idle check right after reset
//   Queue of expected completion records, filled by the testbench top
//   Field compare on every accepted completion
//   Per-test result lines and total counts
`timescale 1ns/100ps
`default_nettype none

module exec_checker import exec_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cmd_ready,
    input  logic      cpl_valid,
    input  logic      cpl_ready,
    input  exec_cpl_t cpl
);

    localparam int IDLE_CYCLES = 4;

    typedef struct packed {
        int        test;
        logic      last;        // Final record of its test
        exec_cpl_t rec;
    } expect_t;

    expect_t exp_q[$];
    expect_t head;

    int   idle_count;
    logic idle_done;
    int   test_errors;
    int   test_records;
    int   tests_passed;
    int   tests_failed;
    int   records_checked;
    int   stray_count;          // Completions with nothing outstanding

    initial begin
        idle_count      = 0;
        idle_done       = 1'b0;
        test_errors     = 0;
        test_records    = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        records_checked = 0;
        stray_count     = 0;
    end

    task automatic push_expected(input int test, input logic last, input exec_cpl_t rec);
        expect_t e;
        e.test = test;
        e.last = last;
        e.rec  = rec;
        exp_q.push_back(e);
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    task automatic compare_field(input int test, input string name,
                                 input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED test %0d %s got %h expected %h", test, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic finish_test(input int test);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d passed, %0d completions", test, test_records);
        end else begin
            tests_failed++;
            $display("test %0d failed, %0d errors in %0d completions",
                     test, test_errors, test_records);
        end
        test_errors  = 0;
        test_records = 0;
    endtask

    // Test 1, quiet outputs before the first command
    always @(posedge clk) begin
        if (rst_n && !idle_done) begin
            compare_field(1, "cpl_valid", 32'(cpl_valid), 32'd0);
            compare_field(1, "cmd_ready", 32'(cmd_ready), 32'd1);
            idle_count++;
            if (idle_count == IDLE_CYCLES) begin
                idle_done <= 1'b1;
                finish_test(1);
            end
        end
    end

    // Completion handshake at this edge
    always @(posedge clk) begin
        if (rst_n && cpl_valid && cpl_ready) begin
            if (exp_q.size() == 0) begin
                $display("Completion with op %h arrived with no command outstanding", cpl.op);
                stray_count++;
            end else begin
                head = exp_q.pop_front();
                records_checked++;
                test_records++;
                compare_field(head.test, "op", 32'(cpl.op), 32'(head.rec.op));
                compare_field(head.test, "result", cpl.result, head.rec.result);
                compare_field(head.test, "branch_taken", 32'(cpl.branch_taken),
                              32'(head.rec.branch_taken));
                compare_field(head.test, "target", cpl.target, head.rec.target);
                compare_field(head.test, "illegal", 32'(cpl.illegal), 32'(head.rec.illegal));
                if (head.last) begin
                    finish_test(head.test);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/exec_tb.sv ====
// Testbench top for the execute subsystem
//   Trace file reader, command driver and random completion back-pressure
//   Drain wait and final verdict
`timescale 1ns/100ps
`default_nettype none

module exec_tb import exec_pkg::*; ();

    localparam int ACCEPT_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT  = 200;
    localparam int IDLE_TIMEOUT   = 50;

    typedef struct packed {
        int        test;
        exec_cmd_t cmd;
        exec_cpl_t exp;
    } trace_line_t;

    logic      clk;
    logic      rst_n;
    logic      cmd_valid;
    logic      cmd_ready;
    exec_cmd_t cmd;
    logic      cpl_valid;
    logic      cpl_ready;
    exec_cpl_t cpl;

    trace_line_t lines[$];
    logic        aborted;       // Timeout or unreadable trace

    tb_clock clk0 (.clk(clk));

    exec_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .cpl_valid (cpl_valid),
        .cpl_ready (cpl_ready),
        .cpl       (cpl)
    );

    exec_checker chk0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_ready (cmd_ready),
        .cpl_valid (cpl_valid),
        .cpl_ready (cpl_ready),
        .cpl       (cpl)
    );

    task automatic load_trace();
        int          fd;
        int          rc;
        int          t;
        string       text;
        logic [31:0] op_v, a, b, res, tk, tg, il;
        trace_line_t l;
        fd = $fopen("tb/exec_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file tb/exec_trace.txt");
            aborted = 1'b1;
            return;
        end
        while (!$feof(fd)) begin
            text = "";
            rc = $fgets(text, fd);
            if (rc > 0) begin
                rc = $sscanf(text, "%d %h %h %h %h %h %h %h", t, op_v, a, b, res, tk, tg, il);
                if (rc == 8) begin  // Comment lines match nothing
                    l = '0;
                    l.test             = t;
                    l.cmd.op           = op_e'(op_v[6:0]);
                    l.cmd.operand1     = a;
                    l.cmd.operand2     = b;
                    l.exp.op           = op_e'(op_v[6:0]);
                    l.exp.result       = res;
                    l.exp.branch_taken = tk[0];
                    l.exp.target       = tg;
                    l.exp.illegal      = il[0];
                    lines.push_back(l);
                end
            end
        end
        $fclose(fd);
        if (lines.size() == 0) begin
            $display("The trace file tb/exec_trace.txt holds no commands");
            aborted = 1'b1;
        end
    endtask

    // Waits for the checker to finish the idle check
    task automatic wait_idle();
        int waited;
        waited = 0;
        while (!chk0.idle_done && waited < IDLE_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (!chk0.idle_done) begin
            $display("Idle check did not finish within %0d cycles", IDLE_TIMEOUT);
            aborted = 1'b1;
        end
    endtask

    // Starts just after a rising edge and returns at the accepting edge
    task automatic send_command(input trace_line_t l, input logic is_last);
        int   waited;
        logic accepted;
        waited   = 0;
        accepted = 1'b0;
        chk0.push_expected(l.test, is_last, l.exp);
        cmd_valid <= 1'b1;
        cmd       <= l.cmd;
        while (!accepted && waited < ACCEPT_TIMEOUT) begin
            @(posedge clk);
            waited++;
            accepted = cmd_ready;
        end
        if (!accepted) begin
            $display("Command op %h of test %0d not accepted within %0d cycles",
                     l.cmd.op, l.test, ACCEPT_TIMEOUT);
            aborted = 1'b1;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        do begin
            @(negedge clk);  // Away from the checker's pop
            waited++;
        end while (chk0.pending() != 0 && waited < DRAIN_TIMEOUT);
        if (chk0.pending() != 0) begin
            $display("%0d completions still outstanding after %0d cycles",
                     chk0.pending(), DRAIN_TIMEOUT);
            aborted = 1'b1;
        end
        for (waited = 0; waited < 4; waited++) begin
            @(negedge clk);  // Room for a repeated completion to show up
        end
    endtask

    // Random completion back-pressure on about a third of the edges
    always @(posedge clk) begin
        if (rst_n) begin
            cpl_ready <= ($urandom % 3) != 0;
        end
    end

    initial begin
        logic is_last;
        void'($urandom(32'hb4cd));
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd       = '0;
        cpl_ready = 1'b1;
        aborted   = 1'b0;
        load_trace();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        wait_idle();
        for (int i = 0; i < lines.size(); i++) begin
            if (i == lines.size() - 1) begin
                is_last = 1'b1;
            end else begin
                is_last = lines[i + 1].test != lines[i].test;
            end
            if (!aborted) begin
                send_command(lines[i], is_last);
            end
        end
        cmd_valid <= 1'b0;
        if (!aborted) begin
            drain();
        end
        $display("Summary: %0d tests passed, %0d tests failed, %0d completions, %0d unexpected",
                 chk0.tests_passed, chk0.tests_failed, chk0.records_checked, chk0.stray_count);
        if (!aborted && chk0.tests_failed == 0 && chk0.stray_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/exec_trace.txt ====
# test op operand1 operand2 result branch_taken target illegal
# test number in decimal, every other column in hex
2 00 00000005 00000003 00000008 0 00000000 0
2 00 ffffffff 00000001 00000000 0 00000000 0
2 00 7fffffff 7fffffff fffffffe 0 00000000 0
2 01 0000000a 00000003 00000007 0 00000000 0
2 01 00000000 00000001 ffffffff 0 00000000 0
2 01 12345678 12345678 00000000 0 00000000 0
2 02 f0f0f0f0 0ff00ff0 00f000f0 0 00000000 0
2 02 deadbeef ffff0000 dead0000 0 00000000 0
2 03 f0f0f0f0 0ff00ff0 fff0fff0 0 00000000 0
2 03 00000000 00000000 00000000 0 00000000 0
2 03 12340000 00005678 12345678 0 00000000 0
3 04 00000040 00000040 00000000 1 00000040 0
3 04 00000040 00000041 00000000 0 00000000 0
3 05 00000080 00000081 00000000 1 00000080 0
3 05 00000080 00000080 00000000 0 00000000 0
3 04 ffffffff ffffffff 00000000 1 ffffffff 0
3 05 00000000 80000000 00000000 1 00000000 0
4 07 00000000 11111111 00000000 0 00000000 0
4 07 00000001 22222222 00000000 0 00000000 0
4 07 000000ff 33333333 00000000 0 00000000 0
4 07 00000010 44444444 00000000 0 00000000 0
4 06 00000000 00000000 11111111 0 00000000 0
4 06 00000001 00000000 22222222 0 00000000 0
4 06 000000ff 00000000 33333333 0 00000000 0
4 06 00000110 00000000 44444444 0 00000000 0
4 07 00000001 55555555 00000000 0 00000000 0
4 06 00000301 00000000 55555555 0 00000000 0
4 06 00000010 00000000 44444444 0 00000000 0
5 08 00000001 00000002 00000000 0 00000000 1
5 7f ffffffff ffffffff 00000000 0 00000000 1
6 00 00000001 00000001 00000002 0 00000000 0
6 07 00000020 cafef00d 00000000 0 00000000 0
6 06 00000020 00000000 cafef00d 0 00000000 0
6 05 00000003 00000004 00000000 1 00000003 0
6 01 00000010 00000001 0000000f 0 00000000 0
6 0a 00000010 00000001 00000000 0 00000000 1
6 06 000000ff 00000000 33333333 0 00000000 0
6 02 ffffffff 0000ffff 0000ffff 0 00000000 0
6 03 00000f00 000000f0 00000ff0 0 00000000 0
6 06 00000001 00000000 55555555 0 00000000 0
6 04 00000005 00000005 00000000 1 00000005 0
6 00 80000000 80000000 00000000 0 00000000 0

// ==== flist.f ====
verilog/exec_pkg.sv
verilog/exec_alu.sv
verilog/data_mem.sv
verilog/exec_stage.sv
verilog/exec_top.sv
tb/tb_clock.sv
tb/exec_checker.sv
tb/exec_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the execute subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module exec_tb -f flist.f

out=$(./obj_dir/Vexec_tb)
echo "$out"

if echo "$out" | grep -qx "TEST PASS"; then
    exit 0
else
    exit 1
fi
